/* hdl/fp_pkg.sv */
// Shared definitions for the non-arithmetic double-precision FPU.
// Holds format constants, operation and sub-function codes, and the
// operand class, flag and result structs. Import with fp_pkg::*.

package fp_pkg;

	////////////////////
	// format constants
	localparam int dbl_width    = 64;
	localparam int dbl_exp_bits = 11;
	localparam int dbl_man_bits = 52;
	localparam int dbl_bias     = 1023;

	localparam int sgl_exp_bits = 8;
	localparam int sgl_man_bits = 23;
	localparam int sgl_bias     = 127;
	localparam int exp_rebias   = dbl_bias - sgl_bias; // 896

	localparam logic [63:0] dbl_qnan = 64'h7ff8_0000_0000_0000; // canonical double NaN
	localparam logic [31:0] sgl_qnan = 32'h7fc0_0000;
	localparam logic [31:0] nan_box  = 32'hffff_ffff; // upper half of a single result

	////////////////////
	// operation codes
	typedef enum logic [2:0] {
		op_sgnj,
		op_classify,
		op_compare,
		op_minmax,
		op_cvt_f2f,
		op_cvt_f2i
	} fp_op_e;

	// sub-function, meaning depends on the operation
	typedef logic [2:0] fp_fn_t;

	localparam fp_fn_t fn_sgnj  = 3'd0;
	localparam fp_fn_t fn_sgnjn = 3'd1;
	localparam fp_fn_t fn_sgnjx = 3'd2;

	localparam fp_fn_t fn_fle   = 3'd0;
	localparam fp_fn_t fn_flt   = 3'd1;
	localparam fp_fn_t fn_feq   = 3'd2;

	localparam fp_fn_t fn_min   = 3'd0;
	localparam fp_fn_t fn_max   = 3'd1;

	localparam fp_fn_t fn_d2s   = 3'd0; // double to single
	localparam fp_fn_t fn_s2d   = 3'd1; // single to double

	localparam fp_fn_t fn_int32 = 3'd0;
	localparam fp_fn_t fn_int64 = 3'd1;

	////////////////////
	// structs
	typedef struct packed {
		logic sign;
		logic is_zero;
		logic is_sub;
		logic is_inf;
		logic is_nan;
		logic is_snan;
		logic is_norm;
	} fp_class_t;

	typedef struct packed {
		logic invalid;
		logic overflow;
		logic underflow;
		logic inexact;
	} fp_flags_t;

	typedef struct packed {
		logic                 valid;
		logic [dbl_width-1:0] value;
		fp_flags_t            flags;
	} fp_result_t;

endpackage

/* hdl/fp_operand_if.sv */
// Operand bundle from the unpack stage to the execution units.
// Carries the captured request and the decoded class of both operands.
// The unpack stage drives it, every unit only reads it.

`timescale 1ns/100ps

interface fp_operand_if import fp_pkg::*; ();

	logic                 valid; // one request in this stage
	fp_op_e               op;
	fp_fn_t               fn;
	logic [dbl_width-1:0] opa;
	logic [dbl_width-1:0] opb;
	fp_class_t            cls_a;
	fp_class_t            cls_b;

	modport unpack
	(
		output valid, op, fn, opa, opb, cls_a, cls_b
	);

	modport unit
	(
		input valid, op, fn, opa, opb, cls_a, cls_b
	);

endinterface

/* hdl/fp_operand_unpack.sv */
// First pipeline stage of the FPU.
// Captures a request on start and registers the class of each operand,
// so the units see operands and classes together one cycle later.

`timescale 1ns/100ps

module fp_operand_unpack import fp_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  fp_op_e               op,
	input  fp_fn_t               fn,
	input  logic [dbl_width-1:0] opa,
	input  logic [dbl_width-1:0] opb,
	fp_operand_if.unpack         opnd
);

	// split a double into its class bits
	function automatic fp_class_t decode(input logic [dbl_width-1:0] x);
		logic [dbl_exp_bits-1:0] ex;
		logic [dbl_man_bits-1:0] mn;
		logic                    exp_max;
		logic                    exp_zero;
		fp_class_t               c;
		ex       = x[dbl_width-2 -: dbl_exp_bits];
		mn       = x[dbl_man_bits-1:0];
		exp_max  = &ex;
		exp_zero = ~|ex;
		c.sign    = x[dbl_width-1];
		c.is_zero = exp_zero & ~|mn;
		c.is_sub  = exp_zero & |mn;
		c.is_inf  = exp_max & ~|mn;
		c.is_nan  = exp_max & |mn;
		c.is_snan = exp_max & |mn & ~mn[dbl_man_bits-1]; // quiet bit clear
		c.is_norm = ~exp_zero & ~exp_max;
		return c;
	endfunction

	always_ff @(posedge clk)
	begin
		if (rst)
			opnd.valid <= 1'b0;
		else
			opnd.valid <= start;
	end

	// payload only moves when a request arrives
	always_ff @(posedge clk)
	begin
		if (start)
		begin
			opnd.op    <= op;
			opnd.fn    <= fn;
			opnd.opa   <= opa;
			opnd.opb   <= opb;
			opnd.cls_a <= decode(opa);
			opnd.cls_b <= decode(opb);
		end
	end

endmodule

/* hdl/fp_sign_compare.sv */
// Sign injection, classify, compare and min/max unit.
// Works on the unpacked operands and registers one result per cycle.
// Only raises its result valid for the four operations it owns.

`timescale 1ns/100ps

module fp_sign_compare import fp_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	fp_operand_if.unit opnd,
	output fp_result_t res
);

	logic [dbl_width-1:0] a;
	logic [dbl_width-1:0] b;
	fp_class_t            ca;
	fp_class_t            cb;
	logic                 both_zero;
	logic                 any_nan;
	logic                 any_snan;
	logic                 order_lt; // total order, -0 below +0
	logic                 is_lt;
	logic                 is_eq;
	logic [9:0]           cls_mask;
	logic [dbl_width-1:0] value_d;
	fp_flags_t            flags_d;
	logic                 res_valid;
	logic [dbl_width-1:0] res_value;
	fp_flags_t            res_flags;

	assign a  = opnd.opa;
	assign b  = opnd.opb;
	assign ca = opnd.cls_a;
	assign cb = opnd.cls_b;

	assign both_zero = ca.is_zero & cb.is_zero;
	assign any_nan   = ca.is_nan | cb.is_nan;
	assign any_snan  = ca.is_snan | cb.is_snan;

	////////////////////
	// sign-magnitude ordering
	assign order_lt = (a[63] != b[63]) ? a[63] :
	                  a[63] ? (b[62:0] < a[62:0]) : (a[62:0] < b[62:0]);
	assign is_lt    = order_lt & ~both_zero; // +0 and -0 compare equal
	assign is_eq    = (a == b) | both_zero;

	// one-hot class mask, RISC-V bit order
	always_comb
	begin
		cls_mask = '0;
		if (ca.is_nan)
			cls_mask[ca.is_snan ? 8 : 9] = 1'b1;
		else if (ca.is_inf)
			cls_mask[ca.sign ? 0 : 7] = 1'b1;
		else if (ca.is_norm)
			cls_mask[ca.sign ? 1 : 6] = 1'b1;
		else if (ca.is_sub)
			cls_mask[ca.sign ? 2 : 5] = 1'b1;
		else
			cls_mask[ca.sign ? 3 : 4] = 1'b1;
	end

	always_comb
	begin
		value_d = '0;
		flags_d = '0;
		case (opnd.op)
			op_sgnj:
				case (opnd.fn)
					fn_sgnjn: value_d = {~b[63], a[62:0]};
					fn_sgnjx: value_d = {a[63] ^ b[63], a[62:0]};
					default:  value_d = {b[63], a[62:0]}; // fn_sgnj
				endcase
			op_classify:
				value_d = {54'd0, cls_mask};
			op_compare:
				case (opnd.fn)
					fn_fle:
					begin
						value_d[0]      = (is_lt | is_eq) & ~any_nan;
						flags_d.invalid = any_nan;
					end
					fn_flt:
					begin
						value_d[0]      = is_lt & ~any_nan;
						flags_d.invalid = any_nan;
					end
					default: // fn_feq, quiet compare
					begin
						value_d[0]      = is_eq & ~any_nan;
						flags_d.invalid = any_snan;
					end
				endcase
			default: // op_minmax
			begin
				if (ca.is_nan & cb.is_nan)
					value_d = dbl_qnan;
				else if (ca.is_nan)
					value_d = b;
				else if (cb.is_nan)
					value_d = a;
				else if (opnd.fn == fn_max)
					value_d = order_lt ? b : a;
				else
					value_d = order_lt ? a : b; // fn_min
				flags_d.invalid = any_snan;
			end
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			res_valid <= 1'b0;
		else
			res_valid <= opnd.valid & (opnd.op inside {op_sgnj, op_classify, op_compare,
			                                           op_minmax});
	end

	always_ff @(posedge clk)
	begin
		res_value <= value_d;
		res_flags <= flags_d;
	end

	assign res = {res_valid, res_value, res_flags};

endmodule

/* hdl/fp_convert.sv */
// Format conversion unit: double to single, single to double, and
// double to signed 32 or 64 bit integer with truncation toward zero.
// Single results are NaN-boxed in the upper word. One result per cycle.

`timescale 1ns/100ps

module fp_convert import fp_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	fp_operand_if.unit opnd,
	output fp_result_t res
);

	logic [dbl_width-1:0]    a;
	fp_class_t               ca;
	logic [12:0]             reb_exp;  // exponent rebiased to single, signed
	logic [sgl_man_bits-1:0] keep_man;
	logic                    rnd_bit;
	logic [35:0]             rnd;      // exponent and mantissa after rounding
	logic [dbl_width-1:0]    d2s_val;
	fp_flags_t               d2s_flags;
	logic [sgl_exp_bits-1:0] s_exp;
	logic [sgl_man_bits-1:0] s_man;
	logic [dbl_width-1:0]    s2d_val;
	fp_flags_t               s2d_flags;
	logic                    is64;
	logic [10:0]             ub;       // unbiased exponent
	logic [127:0]            ext;
	logic [63:0]             int_mag;
	logic [63:0]             int_val;
	logic [63:0]             sat_max;
	logic [63:0]             sat_min;
	logic [63:0]             neg_lim;
	logic [dbl_width-1:0]    f2i_val;
	fp_flags_t               f2i_flags;
	logic                    res_valid;
	logic [dbl_width-1:0]    res_value;
	fp_flags_t               res_flags;

	assign a  = opnd.opa;
	assign ca = opnd.cls_a;

	////////////////////
	// double to single
	assign reb_exp  = {2'b00, a[62:52]} - 13'(exp_rebias);
	assign keep_man = a[dbl_man_bits-1 -: sgl_man_bits];
	assign rnd_bit  = a[dbl_man_bits-sgl_man_bits-1];
	assign rnd      = {reb_exp, keep_man} + 36'(rnd_bit); // carry ripples into exponent

	always_comb
	begin
		d2s_flags = '0;
		if (ca.is_nan)
		begin
			d2s_val           = {nan_box, sgl_qnan};
			d2s_flags.invalid = ca.is_snan;
		end
		else if (ca.is_inf)
			d2s_val = {nan_box, a[63], {sgl_exp_bits{1'b1}}, 23'd0};
		else if (ca.is_zero)
			d2s_val = {nan_box, a[63], 31'd0};
		else if (reb_exp[12] || reb_exp == '0)
		begin
			d2s_val             = {nan_box, a[63], 31'd0}; // flush to signed zero
			d2s_flags.underflow = 1'b1;
			d2s_flags.inexact   = 1'b1;
		end
		else if (rnd[35:23] >= 13'd255)
		begin
			d2s_val            = {nan_box, a[63], {sgl_exp_bits{1'b1}}, 23'd0};
			d2s_flags.overflow = 1'b1;
			d2s_flags.inexact  = 1'b1;
		end
		else
		begin
			d2s_val           = {nan_box, a[63], rnd[30:0]};
			d2s_flags.inexact = |a[28:0]; // any of the dropped bits
		end
	end

	////////////////////
	// single to double, exact
	assign s_exp = a[30 -: sgl_exp_bits];
	assign s_man = a[sgl_man_bits-1:0];

	always_comb
	begin
		s2d_flags = '0;
		if (&s_exp)
		begin
			if (|s_man)
			begin
				s2d_val           = dbl_qnan;
				s2d_flags.invalid = ~s_man[sgl_man_bits-1];
			end
			else
				s2d_val = {a[31], 11'h7ff, 52'd0};
		end
		else if (s_exp == '0)
			s2d_val = {a[31], 63'd0}; // subnormals flush to zero
		else
			s2d_val = {a[31], {3'b000, s_exp} + 11'(exp_rebias), s_man, 29'd0};
	end

	////////////////////
	// double to signed integer
	assign is64    = (opnd.fn == fn_int64);
	assign ub      = a[62:52] - 11'(dbl_bias);
	assign ext     = {75'd0, 1'b1, a[51:0]} << ub[5:0];
	assign int_mag = ext[115:52];
	assign int_val = a[63] ? -int_mag : int_mag;
	assign sat_max = is64 ? 64'h7fff_ffff_ffff_ffff : 64'h0000_0000_7fff_ffff;
	assign sat_min = is64 ? 64'h8000_0000_0000_0000 : 64'hffff_ffff_8000_0000;
	assign neg_lim = is64 ? 64'h8000_0000_0000_0000 : 64'h0000_0000_8000_0000;

	always_comb
	begin
		f2i_flags = '0;
		if (ca.is_nan)
		begin
			f2i_val           = sat_max;
			f2i_flags.invalid = 1'b1;
		end
		else if (a[62:52] < 11'(dbl_bias))
		begin
			f2i_val           = '0; // magnitude below one
			f2i_flags.inexact = ~ca.is_zero;
		end
		else if (ub > 11'd63 || (a[63] ? int_mag > neg_lim : int_mag > sat_max))
		begin
			f2i_val           = a[63] ? sat_min : sat_max;
			f2i_flags.invalid = 1'b1;
		end
		else
		begin
			f2i_val           = is64 ? int_val : {{32{int_val[31]}}, int_val[31:0]};
			f2i_flags.inexact = |ext[51:0];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rst)
			res_valid <= 1'b0;
		else
			res_valid <= opnd.valid & (opnd.op inside {op_cvt_f2f, op_cvt_f2i});
	end

	always_ff @(posedge clk)
	begin
		if (opnd.op == op_cvt_f2i)
		begin
			res_value <= f2i_val;
			res_flags <= f2i_flags;
		end
		else
		begin
			res_value <= (opnd.fn == fn_d2s) ? d2s_val : s2d_val;
			res_flags <= (opnd.fn == fn_d2s) ? d2s_flags : s2d_flags;
		end
	end

	assign res = {res_valid, res_value, res_flags};

endmodule

/* hdl/fp_result_select.sv */
// Output stage of the FPU.
// Takes the one valid unit result, registers value and flags, and pulses
// ready for one cycle per result. Value and flags hold between results.

`timescale 1ns/100ps

module fp_result_select import fp_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  fp_result_t           sc_res,
	input  fp_result_t           cv_res,
	output logic [dbl_width-1:0] result,
	output fp_flags_t            flags,
	output logic                 ready
);

	logic any_valid;

	assign any_valid = sc_res.valid | cv_res.valid; // units never overlap

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ready  <= 1'b0;
			result <= '0;
			flags  <= '0;
		end
		else
		begin
			ready <= any_valid;
			if (sc_res.valid)
			begin
				result <= sc_res.value;
				flags  <= sc_res.flags;
			end
			else if (cv_res.valid)
			begin
				result <= cv_res.value;
				flags  <= cv_res.flags;
			end
		end
	end

endmodule

/* hdl/fp_top.sv */
// Top level of the non-arithmetic double-precision FPU.
// One start pulse per operation; result, flags and a one-cycle ready
// follow two cycles later, in order. There is no back-pressure.

`timescale 1ns/100ps

module fp_top import fp_pkg::*;
(
	input  logic                 clk,
	input  logic                 rst,
	input  logic                 start,
	input  fp_op_e               op,
	input  fp_fn_t               fn,
	input  logic [dbl_width-1:0] opa,
	input  logic [dbl_width-1:0] opb,
	output logic [dbl_width-1:0] result,
	output logic                 ready,
	output logic                 invalid,
	output logic                 overflow,
	output logic                 underflow,
	output logic                 inexact
);

	fp_operand_if opnd_if ();

	fp_result_t sc_res;
	fp_result_t cv_res;
	fp_flags_t  flags;

	fp_operand_unpack unpack_inst
	(
		.clk   (clk),
		.rst   (rst),
		.start (start),
		.op    (op),
		.fn    (fn),
		.opa   (opa),
		.opb   (opb),
		.opnd  (opnd_if.unpack)
	);

	fp_sign_compare sign_compare_inst (.clk(clk), .rst(rst), .opnd(opnd_if.unit), .res(sc_res));

	fp_convert convert_inst (.clk(clk), .rst(rst), .opnd(opnd_if.unit), .res(cv_res));

	fp_result_select result_select_inst
	(
		.clk    (clk),
		.rst    (rst),
		.sc_res (sc_res),
		.cv_res (cv_res),
		.result (result),
		.flags  (flags),
		.ready  (ready)
	);

	// flags out as plain ports
	assign invalid   = flags.invalid;
	assign overflow  = flags.overflow;
	assign underflow = flags.underflow;
	assign inexact   = flags.inexact;

endmodule

/* verification/fp_asserts.sv */
// Concurrent checks on the FPU top-level handshake and flags.
// Bound into fp_top; fail_count keeps the number of failed checks.

`timescale 1ns/100ps

module fp_asserts
(
	input logic clk,
	input logic rst,
	input logic start,
	input logic ready,
	input logic invalid,
	input logic overflow,
	input logic underflow,
	input logic inexact
);

	int         fail_count = 0;
	logic [3:0] flag_bits;

	assign flag_bits = {invalid, overflow, underflow, inexact};

	// fixed latency, one ready per start
	ready_follows_start: assert property (@(posedge clk) disable iff (rst)
		ready == $past(start, 3))
	else
	begin
		$error("ready does not match start three edges earlier");
		fail_count = fail_count + 1;
	end

	ready_low_in_reset: assert property (@(posedge clk) rst |=> !ready)
	else
	begin
		$error("ready high during reset");
		fail_count = fail_count + 1;
	end

	// flags only change together with a result
	flags_rise_with_ready: assert property (@(posedge clk) disable iff (rst)
		|(flag_bits & ~$past(flag_bits)) |-> ready)
	else
	begin
		$error("a flag rose while ready was low");
		fail_count = fail_count + 1;
	end

endmodule

bind fp_top fp_asserts fp_asserts_inst
(
	.clk       (clk),
	.rst       (rst),
	.start     (start),
	.ready     (ready),
	.invalid   (invalid),
	.overflow  (overflow),
	.underflow (underflow),
	.inexact   (inexact)
);

/* verification/fp_tb.sv */
// Directed testbench for the non-arithmetic double-precision FPU.
// Test tasks issue operations through run_op, a monitor matches every
// ready pulse against a queue of expected results, cycles and flags.

`timescale 1ns/100ps

module fp_tb import fp_pkg::*;
();

	////////////////////
	// run length
	localparam int reset_cycles   = 16;
	localparam int op_count       = 220; // all operations of all tests, rounded up
	localparam int timeout_cycles = op_count * 3 + reset_cycles + 100;

	// double operands
	localparam logic [63:0] d_pzero = 64'h0000_0000_0000_0000;
	localparam logic [63:0] d_nzero = 64'h8000_0000_0000_0000;
	localparam logic [63:0] d_one   = 64'h3ff0_0000_0000_0000;
	localparam logic [63:0] d_mone  = 64'hbff0_0000_0000_0000;
	localparam logic [63:0] d_two   = 64'h4000_0000_0000_0000;
	localparam logic [63:0] d_mtwo  = 64'hc000_0000_0000_0000;
	localparam logic [63:0] d_pinf  = 64'h7ff0_0000_0000_0000;
	localparam logic [63:0] d_ninf  = 64'hfff0_0000_0000_0000;
	localparam logic [63:0] d_qnan  = 64'h7ff8_0000_0000_0000;
	localparam logic [63:0] d_snan  = 64'h7ff0_0000_0000_0001;

	localparam fp_flags_t no_flags = 4'b0000;
	localparam fp_flags_t f_nv     = 4'b1000; // invalid
	localparam fp_flags_t f_nx     = 4'b0001; // inexact
	localparam fp_flags_t f_of_nx  = 4'b0101;
	localparam fp_flags_t f_uf_nx  = 4'b0011;

	logic                 clk = 1'b0;
	logic                 rst;
	logic                 start;
	fp_op_e               op;
	fp_fn_t               fn;
	logic [dbl_width-1:0] opa;
	logic [dbl_width-1:0] opb;
	logic [dbl_width-1:0] result;
	logic                 ready;
	logic                 invalid;
	logic                 overflow;
	logic                 underflow;
	logic                 inexact;

	int          cycle         = 0;
	int          value_errors  = 0;
	int          flag_errors   = 0;
	int          timing_errors = 0;
	logic [15:0] lfsr          = 16'd12;

	// expected results, oldest first
	logic [63:0] exp_val_q[$];
	fp_flags_t   exp_flags_q[$];
	int          exp_cycle_q[$];
	string       exp_name_q[$];

	fp_top fp_top_inst
	(
		.clk       (clk),
		.rst       (rst),
		.start     (start),
		.op        (op),
		.fn        (fn),
		.opa       (opa),
		.opb       (opb),
		.result    (result),
		.ready     (ready),
		.invalid   (invalid),
		.overflow  (overflow),
		.underflow (underflow),
		.inexact   (inexact)
	);

	always #50 clk = ~clk;

	always @(posedge clk)
		cycle <= cycle + 1;

	////////////////////
	// helpers
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11+1
	endfunction

	task automatic random_word(output logic [63:0] w);
		w = '0;
		for (int i = 0; i < 64; i++)
		begin
			lfsr = lfsr_next(lfsr);
			w    = {w[62:0], lfsr[0]};
		end
	endtask

	// magnitude of x with the sign bit replaced
	function automatic logic [63:0] set_sign(input logic [63:0] x, input logic s);
		logic [63:0] y;
		y     = x;
		y[63] = s;
		return y;
	endfunction

	function automatic fp_flags_t flags_now();
		return {invalid, overflow, underflow, inexact};
	endfunction

	task automatic check_value(input logic [63:0] got, input logic [63:0] want, input string what);
		if (got !== want)
		begin
			$display("[FAIL] %0d ns: %s gave %h, expected %h", $time, what, got, want);
			value_errors++;
		end
	endtask

	task automatic check_flags(input fp_flags_t got, input fp_flags_t want, input string what);
		if (got !== want)
		begin
			$display("[FAIL] %0d ns: %s flags %b, expected %b", $time, what, got, want);
			flag_errors++;
		end
	endtask

	// called on a falling edge, returns on the next one
	task automatic run_op(input fp_op_e o, input fp_fn_t f, input logic [63:0] a,
	                      input logic [63:0] b, input logic [63:0] want,
	                      input fp_flags_t want_flags, input string what);
		exp_val_q.push_back(want);
		exp_flags_q.push_back(want_flags);
		exp_cycle_q.push_back(cycle + 3); // sampled at the next edge, ready two edges later
		exp_name_q.push_back(what);
		op    = o;
		fn    = f;
		opa   = a;
		opb   = b;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
	endtask

	task automatic drain();
		while (exp_val_q.size() != 0)
			@(negedge clk);
	endtask

	// result monitor, samples mid-cycle
	always @(negedge clk)
	begin
		logic [63:0] ev;
		fp_flags_t   ef;
		int          ec;
		string       en;
		if (!rst && ready)
		begin
			if (exp_val_q.size() == 0)
			begin
				$display("ready pulsed at %0d ns with no operation outstanding", $time);
				timing_errors++;
			end
			else
			begin
				ev = exp_val_q.pop_front();
				ef = exp_flags_q.pop_front();
				ec = exp_cycle_q.pop_front();
				en = exp_name_q.pop_front();
				if (cycle != ec)
				begin
					$display("%s finished in cycle %0d instead of cycle %0d", en, cycle, ec);
					timing_errors++;
				end
				check_value(result, ev, en);
				check_flags(flags_now(), ef, en);
			end
		end
		else if (!rst && exp_cycle_q.size() != 0 && exp_cycle_q[0] == cycle)
		begin
			en = exp_name_q.pop_front();
			void'(exp_val_q.pop_front());
			void'(exp_flags_q.pop_front());
			void'(exp_cycle_q.pop_front());
			$display("no ready for %s in cycle %0d", en, cycle);
			timing_errors++;
		end
	end

	////////////////////
	// tests
	task automatic test_latency();
		int due;
		if (ready !== 1'b0)
		begin
			$display("ready is high right after reset");
			timing_errors++;
		end
		check_flags(flags_now(), no_flags, "flags after reset");
		check_value(result, 64'd0, "result after reset");
		due = cycle + 3;
		run_op(op_sgnj, fn_sgnj, d_one, d_mone, d_mone, no_flags, "latency probe");
		repeat (5)
		begin
			if (ready !== (cycle == due))
			begin
				$display("ready is %b in cycle %0d, single pulse due in cycle %0d",
				         ready, cycle, due);
				timing_errors++;
			end
			@(negedge clk);
		end
	endtask

	task automatic test_sign_inject();
		logic [63:0] a;
		logic [63:0] b;
		for (int i = 0; i < 40; i++)
		begin
			random_word(a);
			random_word(b);
			run_op(op_sgnj, fn_sgnj, a, b, set_sign(a, b[63]), no_flags, "fsgnj");
			run_op(op_sgnj, fn_sgnjn, a, b, set_sign(a, !b[63]), no_flags, "fsgnjn");
			run_op(op_sgnj, fn_sgnjx, a, b, set_sign(a, a[63] != b[63]), no_flags, "fsgnjx");
		end
		drain();
	endtask

	task automatic test_classify();
		run_op(op_classify, 3'd0, d_ninf, '0, 64'd1 << 0, no_flags, "class -inf");
		run_op(op_classify, 3'd0, d_mtwo, '0, 64'd1 << 1, no_flags, "class -normal");
		run_op(op_classify, 3'd0, 64'h800f_ffff_ffff_ffff, '0, 64'd1 << 2, no_flags,
		       "class -subnormal");
		run_op(op_classify, 3'd0, d_nzero, '0, 64'd1 << 3, no_flags, "class -0");
		run_op(op_classify, 3'd0, d_pzero, '0, 64'd1 << 4, no_flags, "class +0");
		run_op(op_classify, 3'd0, 64'h1, '0, 64'd1 << 5, no_flags, "class +subnormal");
		run_op(op_classify, 3'd0, d_one, '0, 64'd1 << 6, no_flags, "class +normal");
		run_op(op_classify, 3'd0, d_pinf, '0, 64'd1 << 7, no_flags, "class +inf");
		run_op(op_classify, 3'd0, d_snan, '0, 64'd1 << 8, no_flags, "class snan");
		run_op(op_classify, 3'd0, d_qnan, '0, 64'd1 << 9, no_flags, "class qnan");
		drain();
	endtask

	task automatic test_compare_minmax();
		run_op(op_compare, fn_fle, d_one, d_two, 64'd1, no_flags, "fle 1 2");
		run_op(op_compare, fn_flt, d_one, d_two, 64'd1, no_flags, "flt 1 2");
		run_op(op_compare, fn_feq, d_one, d_two, 64'd0, no_flags, "feq 1 2");
		run_op(op_compare, fn_flt, d_two, d_one, 64'd0, no_flags, "flt 2 1");
		run_op(op_compare, fn_fle, d_two, d_one, 64'd0, no_flags, "fle 2 1");
		run_op(op_compare, fn_flt, d_mone, d_one, 64'd1, no_flags, "flt -1 1");
		run_op(op_compare, fn_flt, d_one, d_mone, 64'd0, no_flags, "flt 1 -1");
		run_op(op_compare, fn_flt, d_mtwo, d_mone, 64'd1, no_flags, "flt -2 -1");
		run_op(op_compare, fn_fle, d_mone, d_mone, 64'd1, no_flags, "fle -1 -1");
		run_op(op_compare, fn_flt, d_mone, d_mone, 64'd0, no_flags, "flt -1 -1");
		run_op(op_compare, fn_feq, d_mone, d_mone, 64'd1, no_flags, "feq -1 -1");
		run_op(op_compare, fn_feq, d_pzero, d_nzero, 64'd1, no_flags, "feq +0 -0");
		run_op(op_compare, fn_flt, d_nzero, d_pzero, 64'd0, no_flags, "flt -0 +0");
		run_op(op_compare, fn_fle, d_pzero, d_nzero, 64'd1, no_flags, "fle +0 -0");
		run_op(op_compare, fn_feq, d_qnan, d_one, 64'd0, no_flags, "feq qnan");
		run_op(op_compare, fn_feq, d_snan, d_one, 64'd0, f_nv, "feq snan");
		run_op(op_compare, fn_fle, d_qnan, d_one, 64'd0, f_nv, "fle qnan");
		run_op(op_compare, fn_flt, d_one, d_qnan, 64'd0, f_nv, "flt qnan");
		// min and max
		run_op(op_minmax, fn_min, d_one, d_two, d_one, no_flags, "min 1 2");
		run_op(op_minmax, fn_max, d_one, d_two, d_two, no_flags, "max 1 2");
		run_op(op_minmax, fn_min, d_mone, d_one, d_mone, no_flags, "min -1 1");
		run_op(op_minmax, fn_max, d_mtwo, d_mone, d_mone, no_flags, "max -2 -1");
		run_op(op_minmax, fn_min, d_pzero, d_nzero, d_nzero, no_flags, "min +0 -0");
		run_op(op_minmax, fn_max, d_nzero, d_pzero, d_pzero, no_flags, "max -0 +0");
		run_op(op_minmax, fn_min, d_qnan, d_two, d_two, no_flags, "min qnan 2");
		run_op(op_minmax, fn_max, d_one, d_snan, d_one, f_nv, "max 1 snan");
		run_op(op_minmax, fn_min, d_qnan, d_snan, dbl_qnan, f_nv, "min qnan snan");
		run_op(op_minmax, fn_max, d_qnan, d_qnan, dbl_qnan, no_flags, "max qnan qnan");
		drain();
	endtask

	task automatic test_convert();
		// double to single, boxed in the upper word
		run_op(op_cvt_f2f, fn_d2s, d_one, '0, 64'hffff_ffff_3f80_0000, no_flags, "d2s 1.0");
		run_op(op_cvt_f2f, fn_d2s, d_mtwo, '0, 64'hffff_ffff_c000_0000, no_flags, "d2s -2.0");
		run_op(op_cvt_f2f, fn_d2s, 64'h3ff8_0000_0000_0000, '0, 64'hffff_ffff_3fc0_0000,
		       no_flags, "d2s 1.5");
		run_op(op_cvt_f2f, fn_d2s, 64'h3ff0_0000_0000_0001, '0, 64'hffff_ffff_3f80_0000,
		       f_nx, "d2s 1+ulp");
		run_op(op_cvt_f2f, fn_d2s, 64'h3fff_ffff_f000_0000, '0, 64'hffff_ffff_4000_0000,
		       f_nx, "d2s rounding carry");
		run_op(op_cvt_f2f, fn_d2s, 64'h7e00_0000_0000_0000, '0, 64'hffff_ffff_7f80_0000,
		       f_of_nx, "d2s overflow");
		run_op(op_cvt_f2f, fn_d2s, 64'h3800_0000_0000_0000, '0, 64'hffff_ffff_0000_0000,
		       f_uf_nx, "d2s underflow +");
		run_op(op_cvt_f2f, fn_d2s, 64'hb690_0000_0000_0000, '0, 64'hffff_ffff_8000_0000,
		       f_uf_nx, "d2s underflow -");
		run_op(op_cvt_f2f, fn_d2s, d_snan, '0, 64'hffff_ffff_7fc0_0000, f_nv, "d2s snan");
		run_op(op_cvt_f2f, fn_d2s, d_qnan, '0, 64'hffff_ffff_7fc0_0000, no_flags, "d2s qnan");
		run_op(op_cvt_f2f, fn_d2s, d_pinf, '0, 64'hffff_ffff_7f80_0000, no_flags, "d2s +inf");
		run_op(op_cvt_f2f, fn_d2s, d_nzero, '0, 64'hffff_ffff_8000_0000, no_flags, "d2s -0");
		// single to double, exact
		run_op(op_cvt_f2f, fn_s2d, 64'hffff_ffff_3f80_0000, '0, d_one, no_flags, "s2d 1.0");
		run_op(op_cvt_f2f, fn_s2d, 64'h0000_0000_c040_0000, '0, 64'hc008_0000_0000_0000,
		       no_flags, "s2d -3.0");
		run_op(op_cvt_f2f, fn_s2d, 64'h0000_0000_ff80_0000, '0, d_ninf, no_flags, "s2d -inf");
		run_op(op_cvt_f2f, fn_s2d, 64'h0000_0000_7f80_0000, '0, d_pinf, no_flags, "s2d +inf");
		run_op(op_cvt_f2f, fn_s2d, 64'h0000_0000_7fc0_0000, '0, dbl_qnan, no_flags, "s2d qnan");
		// double to signed integer, 32 bit sign-extended
		run_op(op_cvt_f2i, fn_int32, 64'h4045_0000_0000_0000, '0, 64'd42, no_flags, "w 42");
		run_op(op_cvt_f2i, fn_int32, 64'hc045_0000_0000_0000, '0, 64'hffff_ffff_ffff_ffd6,
		       no_flags, "w -42");
		run_op(op_cvt_f2i, fn_int32, 64'h4006_0000_0000_0000, '0, 64'd2, f_nx, "w 2.75");
		run_op(op_cvt_f2i, fn_int32, 64'hc006_0000_0000_0000, '0, 64'hffff_ffff_ffff_fffe,
		       f_nx, "w -2.75");
		run_op(op_cvt_f2i, fn_int32, 64'h3fe0_0000_0000_0000, '0, 64'd0, f_nx, "w 0.5");
		run_op(op_cvt_f2i, fn_int32, 64'hc1e0_0000_0000_0000, '0, 64'hffff_ffff_8000_0000,
		       no_flags, "w -2^31");
		run_op(op_cvt_f2i, fn_int32, 64'h4270_0000_0000_0000, '0, 64'h0000_0000_7fff_ffff,
		       f_nv, "w 2^40");
		run_op(op_cvt_f2i, fn_int32, 64'hc270_0000_0000_0000, '0, 64'hffff_ffff_8000_0000,
		       f_nv, "w -2^40");
		run_op(op_cvt_f2i, fn_int32, d_qnan, '0, 64'h0000_0000_7fff_ffff, f_nv, "w nan");
		// 64 bit
		run_op(op_cvt_f2i, fn_int64, 64'h4045_0000_0000_0000, '0, 64'd42, no_flags, "l 42");
		run_op(op_cvt_f2i, fn_int64, 64'hc045_0000_0000_0000, '0, 64'hffff_ffff_ffff_ffd6,
		       no_flags, "l -42");
		run_op(op_cvt_f2i, fn_int64, 64'h4006_0000_0000_0000, '0, 64'd2, f_nx, "l 2.75");
		run_op(op_cvt_f2i, fn_int64, 64'hc006_0000_0000_0000, '0, 64'hffff_ffff_ffff_fffe,
		       f_nx, "l -2.75");
		run_op(op_cvt_f2i, fn_int64, 64'h3fe0_0000_0000_0000, '0, 64'd0, f_nx, "l 0.5");
		run_op(op_cvt_f2i, fn_int64, 64'h4270_0000_0000_0000, '0, 64'h0000_0100_0000_0000,
		       no_flags, "l 2^40");
		run_op(op_cvt_f2i, fn_int64, 64'h4450_0000_0000_0000, '0, 64'h7fff_ffff_ffff_ffff,
		       f_nv, "l 2^70");
		run_op(op_cvt_f2i, fn_int64, 64'hc450_0000_0000_0000, '0, 64'h8000_0000_0000_0000,
		       f_nv, "l -2^70");
		run_op(op_cvt_f2i, fn_int64, d_qnan, '0, 64'h7fff_ffff_ffff_ffff, f_nv, "l nan");
		drain();
	endtask

	// back-to-back starts alternating between the two units
	task automatic test_burst();
		logic [63:0] a;
		logic [63:0] b;
		random_word(a);
		random_word(b);
		run_op(op_classify, 3'd0, d_snan, '0, 64'd1 << 8, no_flags, "burst class snan");
		run_op(op_cvt_f2f, fn_d2s, 64'h3fff_ffff_f000_0000, '0, 64'hffff_ffff_4000_0000,
		       f_nx, "burst d2s carry");
		run_op(op_compare, fn_fle, d_one, d_two, 64'd1, no_flags, "burst fle");
		run_op(op_cvt_f2i, fn_int32, 64'h4006_0000_0000_0000, '0, 64'd2, f_nx, "burst w 2.75");
		run_op(op_minmax, fn_min, d_pzero, d_nzero, d_nzero, no_flags, "burst min zeros");
		run_op(op_cvt_f2f, fn_s2d, 64'h0000_0000_c040_0000, '0, 64'hc008_0000_0000_0000,
		       no_flags, "burst s2d");
		run_op(op_sgnj, fn_sgnjx, a, b, set_sign(a, a[63] != b[63]), no_flags, "burst fsgnjx");
		run_op(op_cvt_f2i, fn_int64, 64'hc450_0000_0000_0000, '0, 64'h8000_0000_0000_0000,
		       f_nv, "burst l -2^70");
		run_op(op_minmax, fn_max, d_one, d_snan, d_one, f_nv, "burst max snan");
		run_op(op_cvt_f2f, fn_d2s, 64'h7e00_0000_0000_0000, '0, 64'hffff_ffff_7f80_0000,
		       f_of_nx, "burst d2s overflow");
		run_op(op_sgnj, fn_sgnjn, a, b, set_sign(a, !b[63]), no_flags, "burst fsgnjn");
		drain();
	endtask

	////////////////////
	// main sequence
	initial
	begin
		int total;
		rst   = 1'b1;
		start = 1'b0;
		op    = op_sgnj;
		fn    = fn_sgnj;
		opa   = '0;
		opb   = '0;
		repeat (reset_cycles) @(negedge clk);
		rst = 1'b0;

		test_latency();
		test_sign_inject();
		test_classify();
		test_compare_minmax();
		test_convert();
		test_burst();
		repeat (4) @(negedge clk); // catch stray ready pulses

		total = value_errors + flag_errors + timing_errors
		        + fp_top_inst.fp_asserts_inst.fail_count;
		$display("value errors %0d, flag errors %0d, timing errors %0d, assertion failures %0d",
		         value_errors, flag_errors, timing_errors, fp_top_inst.fp_asserts_inst.fail_count);
		if (total == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

	// watchdog
	initial
	begin
		while (cycle < timeout_cycles)
			@(posedge clk);
		$display("tests did not finish within %0d cycles", timeout_cycles);
		$display("ERRORS FOUND");
		$finish;
	end

endmodule

/* compile.f */
hdl/fp_pkg.sv
hdl/fp_operand_if.sv
hdl/fp_operand_unpack.sv
hdl/fp_sign_compare.sv
hdl/fp_convert.sv
hdl/fp_result_select.sv
hdl/fp_top.sv
verification/fp_asserts.sv
verification/fp_tb.sv

/* Makefile */
SIM        = verilator
TOP        = fp_tb
FILELIST   = compile.f
BUILD_DIR  = obj_dir
LOG        = sim.log
SIM_FLAGS  = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing -Wall
RUN_ARGS   = +verilator+error+limit+100
FAIL_MSG   = ERRORS FOUND

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi; \
	exit $$status

lint:
	$(SIM) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
